//--- cart_pkg.sv
package cart_pkg;

	// Widths fixed by the Neo Geo memory map
	localparam int DL_ADDR_W  = 27;
	localparam int OFFSET_W   = 26;
	localparam int P1_ADDR_W  = 23;
	localparam int P2_ADDR_W  = 25;

	// Cart header layout
	localparam int HEADER_LAST = 4095;
	localparam int SIZE_FIRST  = 4;
	localparam int SIZE_LAST   = 27;

	localparam int NUM_REGIONS  = 6;
	localparam int SIZE_TABLE_W = (SIZE_LAST - SIZE_FIRST + 1) * 8;

	localparam logic [7:0] INDEX_CART = 8'd2;

	// Top byte of each bank-3 area
	localparam logic [7:0] SROM_BASE = 8'hF8;
	localparam logic [7:0] LO_BASE   = 8'hDE;
	localparam logic [7:0] SFIX_BASE = 8'hE8;
	localparam logic [7:0] SM1_BASE  = 8'hEC;
	localparam logic [7:0] FIX_BASE  = 8'hE0;
	localparam logic [7:0] MROM_BASE = 8'hF0;

	// Same order as the size table in the .neo header
	typedef enum logic [2:0] {
		REGION_P  = 3'd0,
		REGION_S  = 3'd1,
		REGION_M  = 3'd2,
		REGION_V1 = 3'd3,
		REGION_V2 = 3'd4,
		REGION_C  = 3'd5
	} region_e;

	typedef enum logic [1:0] {
		KIND_SYSTEM = 2'd0,
		KIND_HEADER = 2'd1,
		KIND_DATA   = 2'd2
	} beat_kind_e;

	typedef struct packed {
		beat_kind_e           kind;
		logic [DL_ADDR_W-1:0] addr;
		logic [7:0]           data;
	} tagged_byte_t;

	// v_base is the bank 0-2 start of the item's region:
	// C size for V1 items, C size plus V1 size for V2 items
	typedef struct packed {
		beat_kind_e           kind;
		region_e              region;
		logic [OFFSET_W-1:0]  offset;
		logic [DL_ADDR_W-1:0] addr;
		logic [7:0]           data;
		logic [OFFSET_W-1:0]  v_base;
	} region_beat_t;

endpackage

//--- stream_if.sv
`timescale 1ns/1ps

// Single-item valid/ready link between pipeline stages
interface stream_if #(
	parameter type payload_t = logic [7:0]
);

	logic     valid;
	logic     ready;
	payload_t payload;

	// Payload holds from valid until the transfer
	modport source (
		output valid,
		output payload,
		input  ready
	);

	modport sink (
		input  valid,
		input  payload,
		output ready
	);

endinterface

//--- download_capture.sv
`timescale 1ns/1ps

module download_capture (
	input  logic                          CLK_48M,
	input  logic                          arst_n,
	input  logic                          dl_active,
	input  logic [7:0]                    dl_index,
	input  logic                          dl_valid,
	output logic                          dl_ready,
	input  logic [cart_pkg::DL_ADDR_W-1:0] dl_addr,
	input  logic [7:0]                    dl_data,
	stream_if.source                      out_link
);

	cart_pkg::tagged_byte_t slot;
	cart_pkg::tagged_byte_t next_beat;
	logic                   slot_valid;
	logic                   accept;
	logic                   keep;

	// Slot is free or empties this cycle
	assign dl_ready = !slot_valid || out_link.ready;
	assign accept   = dl_valid && dl_ready;

	// BIOS indices and the cart index only
	assign keep = dl_active &&
		(dl_index == 8'd0 || dl_index == 8'd1 || dl_index == cart_pkg::INDEX_CART);

	always_comb begin
		next_beat.addr = dl_addr;
		next_beat.data = dl_data;
		if (dl_index != cart_pkg::INDEX_CART)
			next_beat.kind = cart_pkg::KIND_SYSTEM;
		else if (dl_addr <= cart_pkg::HEADER_LAST)
			next_beat.kind = cart_pkg::KIND_HEADER;
		else
			next_beat.kind = cart_pkg::KIND_DATA;
	end

	always_ff @(posedge CLK_48M or negedge arst_n) begin
		if (!arst_n) begin
			slot_valid <= 1'b0;
		end else if (accept && keep) begin
			slot_valid <= 1'b1;
		end else if (out_link.ready) begin
			slot_valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (accept && keep)
			slot <= next_beat;
	end

	assign out_link.valid   = slot_valid;
	assign out_link.payload = slot;

endmodule

//--- region_sequencer.sv
`timescale 1ns/1ps

module region_sequencer (
	input  logic     CLK_48M,
	input  logic     arst_n,
	stream_if.sink   in_link,
	stream_if.source out_link,
	output logic     load_done
);

	cart_pkg::tagged_byte_t              in_beat;
	cart_pkg::region_beat_t              slot;
	logic                                slot_valid;
	logic                                walking;
	logic                                take;
	logic                                is_size_byte;
	cart_pkg::region_e                   region;
	logic [cart_pkg::OFFSET_W-1:0]       offset;
	logic [cart_pkg::OFFSET_W-1:0]       offset_inc;
	logic [cart_pkg::SIZE_TABLE_W-1:0]   size_sr;
	logic [cart_pkg::OFFSET_W-1:0]       sizes [cart_pkg::NUM_REGIONS];
	logic [cart_pkg::OFFSET_W-1:0]       cur_size;
	logic [cart_pkg::OFFSET_W-1:0]       next_size;
	logic [cart_pkg::OFFSET_W-1:0]       cv1_sum;

	assign in_beat = in_link.payload;

	// No new item while stepping through regions
	assign in_link.ready = !walking && (!slot_valid || out_link.ready);
	assign take          = in_link.valid && in_link.ready;

	assign is_size_byte = in_beat.addr >= cart_pkg::SIZE_FIRST &&
		in_beat.addr <= cart_pkg::SIZE_LAST;

	// Sizes are 32 bits little endian, only the low 26 bits address SDRAM
	always_comb begin
		for (int i = 0; i < cart_pkg::NUM_REGIONS; i++)
			sizes[i] = size_sr[i*32 +: cart_pkg::OFFSET_W];
	end

	assign cur_size   = sizes[region];
	assign next_size  = (region == cart_pkg::REGION_C) ? '0 : sizes[region + 3'd1];
	assign offset_inc = offset + 1'b1;
	assign cv1_sum    = sizes[cart_pkg::REGION_C] + sizes[cart_pkg::REGION_V1];

	always_ff @(posedge CLK_48M or negedge arst_n) begin
		if (!arst_n) begin
			slot_valid <= 1'b0;
			walking    <= 1'b0;
			region     <= cart_pkg::REGION_P;
			offset     <= '0;
			size_sr    <= '0;
			load_done  <= 1'b0;
		end else begin
			if (take)
				slot_valid <= 1'b1;
			else if (out_link.ready)
				slot_valid <= 1'b0;

			if (walking) begin
				// Current region is full, one step per cycle
				if (region == cart_pkg::REGION_C) begin
					load_done <= 1'b1;
					walking   <= 1'b0;
				end else begin
					region  <= cart_pkg::region_e'(region + 3'd1);
					offset  <= '0;
					walking <= (next_size == '0);
				end
			end else if (take) begin
				case (in_beat.kind)
					cart_pkg::KIND_HEADER: begin
						load_done <= 1'b0;
						region    <= cart_pkg::REGION_P;
						offset    <= '0;
						if (is_size_byte)
							size_sr <= {in_beat.data, size_sr[cart_pkg::SIZE_TABLE_W-1:8]};
						// End of header, skip leading empty regions
						if (in_beat.addr == cart_pkg::HEADER_LAST)
							walking <= (sizes[cart_pkg::REGION_P] == '0);
					end
					cart_pkg::KIND_DATA: begin
						offset  <= offset_inc;
						walking <= (offset_inc == cur_size);
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (take) begin
			slot.kind   <= in_beat.kind;
			slot.region <= region;
			slot.offset <= offset;
			slot.addr   <= in_beat.addr;
			slot.data   <= in_beat.data;
			slot.v_base <= (region == cart_pkg::REGION_V2) ? cv1_sum : sizes[cart_pkg::REGION_C];
		end
	end

	assign out_link.valid   = slot_valid;
	assign out_link.payload = slot;

endmodule

//--- sdram_addr_map.sv
`timescale 1ns/1ps

module sdram_addr_map (
	input  logic                           CLK_48M,
	input  logic                           arst_n,
	stream_if.sink                         in_link,
	output logic                           p1_valid,
	input  logic                           p1_ready,
	output logic [cart_pkg::P1_ADDR_W-1:0] p1_addr,
	output logic [1:0]                     p1_be,
	output logic [15:0]                    p1_data,
	output logic                           p2_valid,
	input  logic                           p2_ready,
	output logic [cart_pkg::P2_ADDR_W-1:0] p2_addr,
	output logic [1:0]                     p2_be,
	output logic [15:0]                    p2_data
);

	cart_pkg::region_beat_t             beat;
	logic                               take;
	logic                               drain;
	logic                               out_valid;
	logic                               out_p2;
	logic [cart_pkg::P2_ADDR_W-1:0]     out_word;
	logic [1:0]                         out_be;
	logic [7:0]                         out_byte;
	logic [cart_pkg::P1_ADDR_W:0]       b3_addr;
	logic [cart_pkg::P2_ADDR_W:0]       b2_addr;
	logic                               to_p2;
	logic                               lane_hi;

	// Fix tile byte order, low five bits
	function automatic logic [4:0] fix_lo(input logic [4:0] a);
		return {a[2:0], ~a[4], a[3]};
	endfunction

	assign beat = in_link.payload;

	assign drain         = out_valid && (out_p2 ? p2_ready : p1_ready);
	assign in_link.ready = !out_valid || drain;
	assign take          = in_link.valid && in_link.ready;

	always_comb begin
		b3_addr = '0;
		b2_addr = '0;
		to_p2   = 1'b0;
		if (beat.kind == cart_pkg::KIND_SYSTEM) begin
			if (beat.addr[23:19] == 5'd0)
				b3_addr = {cart_pkg::SROM_BASE[7:3], beat.addr[18:0]};
			else if (beat.addr[23:17] == 7'd4)
				b3_addr = {cart_pkg::LO_BASE, beat.addr[15:0]};
			else if (beat.addr[23:17] == 7'd5)
				b3_addr = {cart_pkg::SFIX_BASE[7:1], beat.addr[16:5], fix_lo(beat.addr[4:0])};
			else
				b3_addr = {cart_pkg::SM1_BASE[7:2], beat.addr[17:0]};
		end else begin
			case (beat.region)
				cart_pkg::REGION_P:
					b3_addr = beat.offset[23:0];
				cart_pkg::REGION_S:
					b3_addr = {cart_pkg::FIX_BASE[7:3], beat.offset[18:5], fix_lo(beat.offset[4:0])};
				cart_pkg::REGION_M:
					b3_addr = {cart_pkg::MROM_BASE[7:3], beat.offset[18:0]};
				cart_pkg::REGION_V1,
				cart_pkg::REGION_V2: begin
					to_p2   = 1'b1;
					b2_addr = beat.v_base + beat.offset;
				end
				default: begin
					// C ROM planes interleaved by download address
					to_p2   = 1'b1;
					b2_addr = {beat.offset[25:7], beat.addr[5:2], ~beat.addr[6],
						beat.addr[0], beat.addr[1]};
				end
			endcase
		end
	end

	assign lane_hi = to_p2 ? b2_addr[0] : b3_addr[0];

	always_ff @(posedge CLK_48M or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else if (take) begin
			// Header bytes end here
			out_valid <= (beat.kind != cart_pkg::KIND_HEADER);
		end else if (drain) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (take) begin
			out_p2   <= to_p2;
			out_word <= to_p2 ? b2_addr[cart_pkg::P2_ADDR_W:1] : {2'b00, b3_addr[cart_pkg::P1_ADDR_W:1]};
			out_be   <= lane_hi ? 2'b10 : 2'b01;
			out_byte <= beat.data;
		end
	end

	assign p1_valid = out_valid && !out_p2;
	assign p1_addr  = out_word[cart_pkg::P1_ADDR_W-1:0];
	assign p1_be    = out_be;
	assign p1_data  = {out_byte, out_byte};

	assign p2_valid = out_valid && out_p2;
	assign p2_addr  = out_word;
	assign p2_be    = out_be;
	assign p2_data  = {out_byte, out_byte};

endmodule

//--- cart_loader_top.sv
`timescale 1ns/1ps

module cart_loader_top (
	input  logic                           CLK_48M,
	input  logic                           arst_n,

	input  logic                           dl_active,
	input  logic [7:0]                     dl_index,
	input  logic                           dl_valid,
	output logic                           dl_ready,
	input  logic [cart_pkg::DL_ADDR_W-1:0] dl_addr,
	input  logic [7:0]                     dl_data,

	// Bank 3
	output logic                           p1_valid,
	input  logic                           p1_ready,
	output logic [cart_pkg::P1_ADDR_W-1:0] p1_addr,
	output logic [1:0]                     p1_be,
	output logic [15:0]                    p1_data,

	// Banks 0 to 2
	output logic                           p2_valid,
	input  logic                           p2_ready,
	output logic [cart_pkg::P2_ADDR_W-1:0] p2_addr,
	output logic [1:0]                     p2_be,
	output logic [15:0]                    p2_data,

	output logic                           load_done
);

	stream_if #(.payload_t(cart_pkg::tagged_byte_t)) cap_to_seq ();
	stream_if #(.payload_t(cart_pkg::region_beat_t)) seq_to_map ();

	download_capture u_capture (
		.CLK_48M   (CLK_48M),
		.arst_n    (arst_n),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_valid  (dl_valid),
		.dl_ready  (dl_ready),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.out_link  (cap_to_seq)
	);

	region_sequencer u_sequencer (
		.CLK_48M   (CLK_48M),
		.arst_n    (arst_n),
		.in_link   (cap_to_seq),
		.out_link  (seq_to_map),
		.load_done (load_done)
	);

	sdram_addr_map u_addr_map (
		.CLK_48M   (CLK_48M),
		.arst_n    (arst_n),
		.in_link   (seq_to_map),
		.p1_valid  (p1_valid),
		.p1_ready  (p1_ready),
		.p1_addr   (p1_addr),
		.p1_be     (p1_be),
		.p1_data   (p1_data),
		.p2_valid  (p2_valid),
		.p2_ready  (p2_ready),
		.p2_addr   (p2_addr),
		.p2_be     (p2_be),
		.p2_data   (p2_data)
	);

endmodule

//--- cart_assertions.sv
`timescale 1ns/1ps

module cart_assertions (
	input logic        CLK_48M,
	input logic        arst_n,
	input logic        dl_valid,
	input logic        dl_ready,
	input logic [7:0]  dl_index,
	input logic [26:0] dl_addr,
	input logic [7:0]  dl_data,
	input logic        p1_valid,
	input logic        p1_ready,
	input logic [22:0] p1_addr,
	input logic [1:0]  p1_be,
	input logic [15:0] p1_data,
	input logic        p2_valid,
	input logic        p2_ready,
	input logic [24:0] p2_addr,
	input logic [1:0]  p2_be,
	input logic [15:0] p2_data
);

	// Download side holds its byte until accepted
	dl_hold: assert property (@(posedge CLK_48M) disable iff (!arst_n)
		dl_valid && !dl_ready |=> dl_valid && $stable(dl_index) && $stable(dl_addr)
			&& $stable(dl_data))
		else $error("download byte changed or dropped before dl_ready");

	p1_hold: assert property (@(posedge CLK_48M) disable iff (!arst_n)
		p1_valid && !p1_ready |=> p1_valid && $stable(p1_addr) && $stable(p1_be)
			&& $stable(p1_data))
		else $error("port 1 write changed or dropped before p1_ready");

	p2_hold: assert property (@(posedge CLK_48M) disable iff (!arst_n)
		p2_valid && !p2_ready |=> p2_valid && $stable(p2_addr) && $stable(p2_be)
			&& $stable(p2_data))
		else $error("port 2 write changed or dropped before p2_ready");

	one_port: assert property (@(posedge CLK_48M) disable iff (!arst_n)
		!(p1_valid && p2_valid))
		else $error("both write ports valid in the same cycle");

endmodule

bind cart_loader_top cart_assertions u_assertions (
	.CLK_48M  (CLK_48M),
	.arst_n   (arst_n),
	.dl_valid (dl_valid),
	.dl_ready (dl_ready),
	.dl_index (dl_index),
	.dl_addr  (dl_addr),
	.dl_data  (dl_data),
	.p1_valid (p1_valid),
	.p1_ready (p1_ready),
	.p1_addr  (p1_addr),
	.p1_be    (p1_be),
	.p1_data  (p1_data),
	.p2_valid (p2_valid),
	.p2_ready (p2_ready),
	.p2_addr  (p2_addr),
	.p2_be    (p2_be),
	.p2_data  (p2_data)
);

//--- cart_checker.sv
`timescale 1ns/1ps

module cart_checker (
	input  logic        CLK_48M,
	input  logic        arst_n,
	input  logic        p1_valid,
	input  logic        p1_ready,
	input  logic [22:0] p1_addr,
	input  logic [1:0]  p1_be,
	input  logic [15:0] p1_data,
	input  logic        p2_valid,
	input  logic        p2_ready,
	input  logic [24:0] p2_addr,
	input  logic [1:0]  p2_be,
	input  logic [15:0] p2_data,
	input  logic        load_done,
	output int          error_count
);

	typedef struct packed {
		logic [24:0] addr;
		logic [1:0]  be;
		logic [15:0] data;
	} write_t;

	write_t exp_p1 [$];
	write_t exp_p2 [$];
	int     errors = 0;

	assign error_count = errors;

	task automatic add_expected(input int port, input logic [24:0] addr,
		input logic [1:0] be, input logic [15:0] data);
		write_t w;
		w.addr = addr;
		w.be   = be;
		w.data = data;
		if (port == 1)
			exp_p1.push_back(w);
		else
			exp_p2.push_back(w);
	endtask

	function automatic int pending_writes();
		return exp_p1.size() + exp_p2.size();
	endfunction

	task automatic check_load_done(input logic want);
		if (load_done !== want) begin
			$display("FAIL %0t: load_done is %b, expected %b", $time, load_done, want);
			errors++;
		end
	endtask

	task automatic check_write(input int port, input write_t got);
		write_t want;
		logic   have;
		have = 1'b0;
		if (port == 1 && exp_p1.size() > 0) begin
			want = exp_p1.pop_front();
			have = 1'b1;
		end else if (port == 2 && exp_p2.size() > 0) begin
			want = exp_p2.pop_front();
			have = 1'b1;
		end
		if (!have) begin
			$display("Unexpected write on port %0d at time %0t, address %h", port, $time,
				got.addr);
			errors++;
		end else if (got !== want) begin
			$display("FAIL %0t: port %0d wrote addr %h be %b data %h, expected addr %h be %b data %h",
				$time, port, got.addr, got.be, got.data, want.addr, want.be, want.data);
			errors++;
		end
	endtask

	// Sampled on the edge where the transfer happens
	always @(posedge CLK_48M) begin
		if (arst_n && p1_valid && p1_ready)
			check_write(1, {{2'b00, p1_addr}, p1_be, p1_data});
		if (arst_n && p2_valid && p2_ready)
			check_write(2, {p2_addr, p2_be, p2_data});
	end

endmodule

//--- tb_cart_loader.sv
`timescale 1ns/1ps

module tb_cart_loader;

	logic        CLK_48M;
	logic        arst_n;
	logic        dl_active;
	logic [7:0]  dl_index;
	logic        dl_valid;
	logic        dl_ready;
	logic [26:0] dl_addr;
	logic [7:0]  dl_data;
	logic        p1_valid;
	logic        p1_ready;
	logic [22:0] p1_addr;
	logic [1:0]  p1_be;
	logic [15:0] p1_data;
	logic        p2_valid;
	logic        p2_ready;
	logic [24:0] p2_addr;
	logic [1:0]  p2_be;
	logic [15:0] p2_data;
	logic        load_done;

	int          checker_errors;
	int          tb_errors;
	logic        timed_out;
	integer      seed;
	logic [31:0] hdr_size [6];

	cart_loader_top u_dut (
		.CLK_48M   (CLK_48M),
		.arst_n    (arst_n),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_valid  (dl_valid),
		.dl_ready  (dl_ready),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.p1_valid  (p1_valid),
		.p1_ready  (p1_ready),
		.p1_addr   (p1_addr),
		.p1_be     (p1_be),
		.p1_data   (p1_data),
		.p2_valid  (p2_valid),
		.p2_ready  (p2_ready),
		.p2_addr   (p2_addr),
		.p2_be     (p2_be),
		.p2_data   (p2_data),
		.load_done (load_done)
	);

	cart_checker u_checker (
		.CLK_48M     (CLK_48M),
		.arst_n      (arst_n),
		.p1_valid    (p1_valid),
		.p1_ready    (p1_ready),
		.p1_addr     (p1_addr),
		.p1_be       (p1_be),
		.p1_data     (p1_data),
		.p2_valid    (p2_valid),
		.p2_ready    (p2_ready),
		.p2_addr     (p2_addr),
		.p2_be       (p2_be),
		.p2_data     (p2_data),
		.load_done   (load_done),
		.error_count (checker_errors)
	);

	initial begin
		CLK_48M = 1'b0;
		forever #50 CLK_48M = ~CLK_48M;
	end

	// Random back-pressure on both ports
	initial begin
		seed = 32'h22ef;
		forever begin
			@(negedge CLK_48M);
			p1_ready = ($random(seed) % 4) != 0;
			p2_ready = ($random(seed) % 3) != 0;
		end
	end

	task automatic send_byte(input logic [7:0] idx, input logic [26:0] addr,
		input logic [7:0] data);
		int   waited;
		logic taken;
		waited   = 0;
		taken    = 1'b0;
		dl_index = idx;
		dl_addr  = addr;
		dl_data  = data;
		dl_valid = 1'b1;
		while (!taken && waited < 2000) begin
			@(posedge CLK_48M);
			taken = dl_ready;
			waited++;
		end
		@(negedge CLK_48M);
		dl_valid = 1'b0;
		if (!taken) begin
			$display("Timeout: dl_ready stayed low for 2000 cycles at address %h", addr);
			tb_errors++;
			timed_out = 1'b1;
		end
	endtask

	// Full 4 KB header with the size table at bytes 4 to 27
	task automatic send_header();
		logic [7:0] b;
		int         r;
		for (int a = 0; a <= 4095 && !timed_out; a++) begin
			b = 8'h00;
			if (a >= 4 && a <= 27) begin
				r = (a - 4) / 4;
				b = hdr_size[r][((a - 4) % 4) * 8 +: 8];
			end
			send_byte(8'd2, 27'(a), b);
		end
	endtask

	task automatic wait_load_done();
		int waited;
		waited = 0;
		while (!(load_done && u_checker.pending_writes() == 0) && waited < 5000) begin
			@(negedge CLK_48M);
			waited++;
		end
		if (!(load_done && u_checker.pending_writes() == 0)) begin
			$display("Timeout: load_done or %0d expected writes still missing",
				u_checker.pending_writes());
			tb_errors++;
			timed_out = 1'b1;
		end
	endtask

	initial begin
		int          fd;
		int          n;
		int          count;
		int          port;
		int          lvl;
		string       line;
		logic [7:0]  idx;
		logic [26:0] addr;
		logic [7:0]  data;
		logic [7:0]  step;
		logic [24:0] waddr;
		logic [1:0]  be;
		logic [15:0] wdata;

		tb_errors = 0;
		timed_out = 1'b0;
		arst_n    = 1'b0;
		dl_active = 1'b0;
		dl_index  = 8'd0;
		dl_valid  = 1'b0;
		dl_addr   = '0;
		dl_data   = 8'd0;
		p1_ready  = 1'b0;
		p2_ready  = 1'b0;
		repeat (4) @(posedge CLK_48M);
		@(negedge CLK_48M);
		arst_n    = 1'b1;
		dl_active = 1'b1;

		fd = $fopen("cart_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open cart_patterns.txt");
			tb_errors++;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() == 0 || line[0] == "#" || line[0] == "\n")
					continue;
				case (line[0])
					"D": begin
						n = $sscanf(line, "D %h %h %d %h %h", idx, addr, count, data, step);
						if (n != 5) begin
							$display("Malformed download line: %s", line);
							tb_errors++;
						end
						for (int i = 0; i < count && n == 5 && !timed_out; i++)
							send_byte(idx, addr + 27'(i), data + 8'(i) * step);
					end
					"H": begin
						n = $sscanf(line, "H %d %d %d %d %d %d", hdr_size[0], hdr_size[1],
							hdr_size[2], hdr_size[3], hdr_size[4], hdr_size[5]);
						if (n != 6) begin
							$display("Malformed header line: %s", line);
							tb_errors++;
						end else begin
							send_header();
						end
					end
					"E": begin
						n = $sscanf(line, "E %d %h %h %h", port, waddr, be, wdata);
						if (n != 4) begin
							$display("Malformed expect line: %s", line);
							tb_errors++;
						end else begin
							u_checker.add_expected(port, waddr, be, wdata);
						end
					end
					"L": begin
						n = $sscanf(line, "L %d", lvl);
						if (n != 1) begin
							$display("Malformed load_done line: %s", line);
							tb_errors++;
						end else begin
							u_checker.check_load_done(lvl[0]);
						end
					end
					"W":
						wait_load_done();
					default: begin
						$display("Unknown pattern line: %s", line);
						tb_errors++;
					end
				endcase
			end
			$fclose(fd);
		end

		dl_active = 1'b0;
		$display("Errors: checker %0d, testbench %0d", checker_errors, tb_errors);
		if (checker_errors == 0 && tb_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- cart_patterns.txt
# D index(h) addr(h) count(d) data(h) step(h) | H sizes P S M V1 V2 C (d)
# E port(d) word_addr(h) lane_enable(h) data(h) | L load_done(d) | W wait load_done
E 1 7c0000 2 a1a1
E 1 6f0001 1 b2b2
E 1 740006 1 c3c3
E 1 760002 2 d4d4
D 0 000001 1 a1 0
D 0 080002 1 b2 0
D 0 0a0013 1 c3 0
D 1 0c0005 1 d4 0
H 4 4 2 2 2 4
E 1 000000 1 1010
E 1 000000 2 1111
E 1 000001 1 1212
E 1 000001 2 1313
E 1 700001 1 1414
E 1 700003 1 1515
E 1 700005 1 1616
E 1 700007 1 1717
E 1 780000 1 1818
E 1 780000 2 1919
E 2 000002 1 1a1a
E 2 000002 2 1b1b
E 2 000003 1 1c1c
E 2 000003 2 1d1d
E 2 00000e 2 1e1e
E 2 00000f 2 1f1f
E 2 000012 1 2020
E 2 000013 1 2121
D 2 1000 17 10 1
L 0
D 2 1011 1 21 0
W
H 2 0 0 2 0 2
E 1 000000 1 4040
E 1 000000 2 4141
E 2 000001 1 4242
E 2 000001 2 4343
E 2 000006 1 4444
E 2 000007 1 4545
D 2 1000 5 40 1
L 0
D 2 1005 1 45 0
W

//--- flist.f
cart_pkg.sv
stream_if.sv
download_capture.sv
region_sequencer.sv
sdram_addr_map.sv
cart_loader_top.sv
cart_assertions.sv
cart_checker.sv
tb_cart_loader.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
	-f flist.f \
	--top-module tb_cart_loader \
	-Mdir obj_dir -o sim_cart_loader

./obj_dir/sim_cart_loader > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
	exit 1
fi
if ! grep -q "test passed" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0
